//--- common/mips_isa_pkg.sv
package mips_isa_pkg;

	localparam int XLEN       = 32;	// Data and instruction width
	localparam int REG_ADDR_W = 5;	// 32 architectural registers
	localparam int OPCODE_W   = 6;	// instr[31:26]
	localparam int FUNCT_W    = 6;	// instr[5:0]
	localparam int IMM_W      = 16;	// instr[15:0]
	localparam int JADDR_W    = 26;	// instr[25:0], word target

	// Primary opcodes
	localparam logic [OPCODE_W-1:0] OP_RTYPE    = 6'b000000;	// Decoded by funct
	localparam logic [OPCODE_W-1:0] OP_REGIMM   = 6'b000001;	// Decoded by rt
	localparam logic [OPCODE_W-1:0] OP_J        = 6'b000010;
	localparam logic [OPCODE_W-1:0] OP_JAL      = 6'b000011;
	localparam logic [OPCODE_W-1:0] OP_BEQ      = 6'b000100;
	localparam logic [OPCODE_W-1:0] OP_BNE      = 6'b000101;
	localparam logic [OPCODE_W-1:0] OP_ADDI     = 6'b001000;
	localparam logic [OPCODE_W-1:0] OP_ADDIU    = 6'b001001;
	localparam logic [OPCODE_W-1:0] OP_ANDI     = 6'b001100;
	localparam logic [OPCODE_W-1:0] OP_ORI      = 6'b001101;
	localparam logic [OPCODE_W-1:0] OP_XORI     = 6'b001110;
	localparam logic [OPCODE_W-1:0] OP_LUI      = 6'b001111;
	localparam logic [OPCODE_W-1:0] OP_SPECIAL2 = 6'b011100;	// Only MUL here
	localparam logic [OPCODE_W-1:0] OP_LB       = 6'b100000;
	localparam logic [OPCODE_W-1:0] OP_LW       = 6'b100011;
	localparam logic [OPCODE_W-1:0] OP_SB       = 6'b101000;
	localparam logic [OPCODE_W-1:0] OP_SW       = 6'b101011;

	// R-type funct codes
	localparam logic [FUNCT_W-1:0] FN_SLL  = 6'b000000;
	localparam logic [FUNCT_W-1:0] FN_SRL  = 6'b000010;
	localparam logic [FUNCT_W-1:0] FN_SRA  = 6'b000011;
	localparam logic [FUNCT_W-1:0] FN_JR   = 6'b001000;
	localparam logic [FUNCT_W-1:0] FN_JALR = 6'b001001;
	localparam logic [FUNCT_W-1:0] FN_ADD  = 6'b100000;
	localparam logic [FUNCT_W-1:0] FN_ADDU = 6'b100001;
	localparam logic [FUNCT_W-1:0] FN_SUB  = 6'b100010;
	localparam logic [FUNCT_W-1:0] FN_SUBU = 6'b100011;
	localparam logic [FUNCT_W-1:0] FN_AND  = 6'b100100;
	localparam logic [FUNCT_W-1:0] FN_OR   = 6'b100101;
	localparam logic [FUNCT_W-1:0] FN_XOR  = 6'b100110;
	localparam logic [FUNCT_W-1:0] FN_NOR  = 6'b100111;
	localparam logic [FUNCT_W-1:0] FN_SLT  = 6'b101010;
	localparam logic [FUNCT_W-1:0] FN_MUL  = 6'b000010;	// Under SPECIAL2, same code as SRL

	// REGIMM rt codes
	localparam logic [REG_ADDR_W-1:0] RT_BGEZ   = 5'b00001;
	localparam logic [REG_ADDR_W-1:0] RT_BGEZAL = 5'b10001;

	localparam logic [REG_ADDR_W-1:0] RA_REG = 5'd31;	// Link register

endpackage

//--- common/core_ctrl_pkg.sv
package core_ctrl_pkg;

	typedef enum logic [1:0] {
		PC_BRANCH = 2'b00,	// PC+1+imm when zero matches branch_eq
		PC_JUMP   = 2'b01,	// Absolute word target from instr
		PC_REG    = 2'b10,	// Target held in rs
		PC_SEQ    = 2'b11	// PC+1
	} pc_src_e;

	typedef enum logic [1:0] {
		DST_RT = 2'd0,	// Two-register forms
		DST_RD = 2'd1,	// Three-register forms
		DST_RA = 2'd2	// Register 31
	} reg_dst_e;

	typedef enum logic [1:0] {
		WB_ALU  = 2'd0,
		WB_MEM  = 2'd1,
		WB_LINK = 2'd2	// Return address PC+1
	} wb_src_e;

	// Final ALU operation
	typedef enum logic [3:0] {
		ALU_ADD   = 4'd0,
		ALU_SUB   = 4'd1,
		ALU_AND   = 4'd2,
		ALU_NOR   = 4'd3,
		ALU_OR    = 4'd4,
		ALU_XOR   = 4'd5,
		ALU_FUNCT = 4'd6,	// Request only, resolved by alu_control
		ALU_GEZ   = 4'd7,	// 0 when a >= 0, else 1
		ALU_MUL   = 4'd8,
		ALU_LUI   = 4'd9,
		ALU_SLT   = 4'd10,
		ALU_SLL   = 4'd11,
		ALU_SRL   = 4'd12,
		ALU_SRA   = 4'd13
	} alu_op_e;

	// Decoder request uses ADD..XOR except NOR, plus FUNCT, GEZ, LUI and MUL
	typedef alu_op_e alu_class_e;

endpackage

//--- rtl/control/control_unit.sv
`timescale 1ns/10ps
module control_unit import mips_isa_pkg::*, core_ctrl_pkg::*; (
	input  logic [OPCODE_W-1:0]   opcode,
	input  logic [FUNCT_W-1:0]    funct,
	input  logic [REG_ADDR_W-1:0] rt,	// Selects BGEZ or BGEZAL
	output pc_src_e               pc_src,
	output reg_dst_e              reg_dst,
	output wb_src_e               wb_src,
	output alu_class_e            alu_class,
	output logic                  alu_imm,	// Operand B is the immediate
	output logic                  reg_we,
	output logic                  mem_we,
	output logic                  branch_eq,	// Branch when zero equals this
	output logic                  imm_signed,
	output logic                  mem_byte	// Byte access, else word
);

	always_comb
	begin
		pc_src     = PC_SEQ;	// Defaults give a NOP
		reg_dst    = DST_RT;
		wb_src     = WB_ALU;
		alu_class  = ALU_ADD;
		alu_imm    = 1'b0;
		reg_we     = 1'b0;
		mem_we     = 1'b0;
		branch_eq  = 1'b1;
		imm_signed = 1'b1;
		mem_byte   = 1'b0;
		case (opcode)
			OP_RTYPE:
			begin
				case (funct)
					FN_JR:
						pc_src = PC_REG;
					FN_JALR:
					begin
						pc_src  = PC_REG;
						reg_dst = DST_RD;	// rd holds the link, 31 by convention
						wb_src  = WB_LINK;
						reg_we  = 1'b1;
					end
					default:
					begin
						reg_dst   = DST_RD;
						alu_class = ALU_FUNCT;	// alu_control reads funct
						reg_we    = 1'b1;
					end
				endcase
			end
			OP_SPECIAL2:
			begin
				if (funct == FN_MUL)
				begin
					reg_dst   = DST_RD;
					alu_class = ALU_MUL;
					reg_we    = 1'b1;
				end
			end
			OP_REGIMM:
			begin
				case (rt)
					RT_BGEZ:
					begin
						pc_src    = PC_BRANCH;
						alu_class = ALU_GEZ;	// zero set when rs >= 0
					end
					RT_BGEZAL:
					begin
						pc_src    = PC_BRANCH;
						alu_class = ALU_GEZ;
						reg_dst   = DST_RA;
						wb_src    = WB_LINK;	// Link written taken or not
						reg_we    = 1'b1;
					end
					default: ;
				endcase
			end
			OP_ADDI, OP_ADDIU:
			begin
				alu_imm = 1'b1;
				reg_we  = 1'b1;
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
			begin
				alu_imm    = 1'b1;
				reg_we     = 1'b1;
				imm_signed = 1'b0;	// Logic immediates are zero-extended
				case (opcode)
					OP_ANDI: alu_class = ALU_AND;
					OP_ORI:  alu_class = ALU_OR;
					OP_XORI: alu_class = ALU_XOR;
					default: alu_class = ALU_LUI;
				endcase
			end
			OP_BEQ, OP_BNE:
			begin
				pc_src    = PC_BRANCH;
				alu_class = ALU_SUB;	// zero means rs == rt
				branch_eq = (opcode == OP_BEQ);
			end
			OP_LW, OP_LB:
			begin
				alu_imm  = 1'b1;	// Base plus offset
				wb_src   = WB_MEM;
				reg_we   = 1'b1;
				mem_byte = (opcode == OP_LB);
			end
			OP_SW, OP_SB:
			begin
				alu_imm  = 1'b1;
				mem_we   = 1'b1;
				mem_byte = (opcode == OP_SB);
			end
			OP_J:
				pc_src = PC_JUMP;
			OP_JAL:
			begin
				pc_src  = PC_JUMP;
				reg_dst = DST_RA;
				wb_src  = WB_LINK;
				reg_we  = 1'b1;
			end
			default: ;	// Unsupported opcode runs as NOP
		endcase
	end

	// A store never also writes the register file
	a_we_excl: assert final (!(reg_we && mem_we))
		else $error("control_unit: reg_we and mem_we together, opcode %b", opcode);

endmodule

//--- rtl/control/alu_control.sv
`timescale 1ns/10ps
module alu_control import mips_isa_pkg::*, core_ctrl_pkg::*; (
	input  alu_class_e         alu_class,
	input  logic [FUNCT_W-1:0] funct,
	output alu_op_e            alu_op
);

	logic funct_known;	// funct is in the R-type table

	always_comb
	begin
		alu_op      = alu_class;	// Explicit classes pass through
		funct_known = 1'b1;
		if (alu_class == ALU_FUNCT)
		begin
			case (funct)
				FN_ADD, FN_ADDU: alu_op = ALU_ADD;	// No overflow trap
				FN_SUB, FN_SUBU: alu_op = ALU_SUB;
				FN_AND:          alu_op = ALU_AND;
				FN_OR:           alu_op = ALU_OR;
				FN_XOR:          alu_op = ALU_XOR;
				FN_NOR:          alu_op = ALU_NOR;
				FN_SLT:          alu_op = ALU_SLT;
				FN_SLL:          alu_op = ALU_SLL;
				FN_SRL:          alu_op = ALU_SRL;
				FN_SRA:          alu_op = ALU_SRA;
				default:
				begin
					alu_op      = ALU_ADD;
					funct_known = 1'b0;
				end
			endcase
		end
	end

	// Decoder sent a funct-coded R-type the table cannot resolve
	a_funct_known: assert final ($isunknown(alu_class) || funct_known)
		else $error("alu_control: unknown funct %b under ALU_FUNCT", funct);

endmodule

//--- rtl/execute/alu.sv
`timescale 1ns/10ps
module alu import mips_isa_pkg::*, core_ctrl_pkg::*; (
	input  logic [XLEN-1:0] a,	// rs
	input  logic [XLEN-1:0] b,	// rt or immediate
	input  logic [4:0]      shamt,
	input  alu_op_e         alu_op,
	output logic [XLEN-1:0] result,
	output logic            zero
);

	always_comb
	begin
		case (alu_op)
			ALU_ADD: result = a + b;
			ALU_SUB: result = a - b;
			ALU_AND: result = a & b;
			ALU_OR:  result = a | b;
			ALU_XOR: result = a ^ b;
			ALU_NOR: result = ~(a | b);
			ALU_SLT: result = XLEN'($signed(a) < $signed(b));
			ALU_SLL: result = b << shamt;	// Shifts act on rt
			ALU_SRL: result = b >> shamt;
			ALU_SRA: result = $unsigned($signed(b) >>> shamt);
			ALU_GEZ: result = XLEN'(a[XLEN-1]);	// Sign bit of rs
			ALU_LUI: result = {b[IMM_W-1:0], {(XLEN-IMM_W){1'b0}}};
			ALU_MUL: result = $signed(a) * $signed(b);	// Low word of product
			default: result = '0;
		endcase
	end

	assign zero = (result == '0);	// Feeds branch decision

endmodule

//--- rtl/execute/reg_file.sv
`timescale 1ns/10ps
module reg_file import mips_isa_pkg::*; (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic [REG_ADDR_W-1:0] rs_addr,
	input  logic [REG_ADDR_W-1:0] rt_addr,
	output logic [XLEN-1:0]       rs_data,
	output logic [XLEN-1:0]       rt_data,
	input  logic                  we,	// Already qualified by run
	input  logic [REG_ADDR_W-1:0] wr_addr,
	input  logic [XLEN-1:0]       wr_data
);

	logic [XLEN-1:0] regs [2**REG_ADDR_W];

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < 2**REG_ADDR_W; i++)
			begin
				regs[i] <= '0;
			end
		end
		else if (we && wr_addr != '0)	// r0 is hardwired
		begin
			regs[wr_addr] <= wr_data;
		end
	end

	assign rs_data = regs[rs_addr];	// Combinational reads
	assign rt_data = regs[rt_addr];

	// A write aimed at r0 must leave it zero on the next cycle
	a_r0_zero: assert property (@(posedge clk) disable iff (!rst_n)
		(we && wr_addr == '0) |=> (regs[0] == '0))
		else $error("reg_file: r0 changed after a write to it");

endmodule

//--- rtl/fetch/instr_mem.sv
`timescale 1ns/10ps
module instr_mem import mips_isa_pkg::*; #(
	parameter  int IMEM_WORDS = 64,
	localparam int AW         = $clog2(IMEM_WORDS)
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic [AW-1:0]   pc,	// Word address
	output logic [XLEN-1:0] instr,
	input  logic            load_we,
	input  logic [AW-1:0]   load_addr,
	input  logic [XLEN-1:0] load_data
);

	logic [XLEN-1:0] mem [IMEM_WORDS];

	assign instr = mem[pc];	// Asynchronous fetch

	// Program load port
	always_ff @(posedge clk)
	begin
		if (rst_n && load_we)	// Ignore strobes during reset
		begin
			mem[load_addr] <= load_data;
		end
	end

endmodule

//--- rtl/fetch/pc_unit.sv
`timescale 1ns/10ps
module pc_unit import mips_isa_pkg::*, core_ctrl_pkg::*; #(
	parameter  int IMEM_WORDS = 64,	// Power of two, PC wraps here
	localparam int AW         = $clog2(IMEM_WORDS)
) (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               run,	// Low holds the PC for loading
	input  pc_src_e            pc_src,
	input  logic               branch_eq,
	input  logic               zero,
	input  logic [XLEN-1:0]    imm_ext,	// Branch offset in words
	input  logic [JADDR_W-1:0] jaddr,
	input  logic [XLEN-1:0]    rs_data,
	output logic [AW-1:0]      pc,
	output logic [AW-1:0]      pc_plus1
);

	logic [AW-1:0] pc_next;
	logic          take_branch;

	assign pc_plus1    = pc + 1'b1;
	assign take_branch = (zero == branch_eq);

	always_comb
	begin
		case (pc_src)
			PC_BRANCH: pc_next = take_branch ? pc_plus1 + imm_ext[AW-1:0] : pc_plus1;
			PC_JUMP:   pc_next = jaddr[AW-1:0];	// Word target, upper bits wrap
			PC_REG:    pc_next = rs_data[AW-1:0];
			default:   pc_next = pc_plus1;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			pc <= '0;
		end
		else if (run)
		begin
			pc <= pc_next;	// One instruction per clock
		end
	end

endmodule

//--- rtl/data_mem.sv
`timescale 1ns/10ps
module data_mem import mips_isa_pkg::*; #(
	parameter  int DMEM_WORDS = 64,
	localparam int AW         = $clog2(DMEM_WORDS)
) (
	input  logic            clk,
	input  logic            rst_n,
	input  logic            we,
	input  logic            byte_mode,
	input  logic [XLEN-1:0] addr,	// Byte address
	input  logic [XLEN-1:0] wdata,
	output logic [XLEN-1:0] rdata
);

	logic [XLEN-1:0] mem [DMEM_WORDS];
	logic [AW-1:0]   word_idx;
	logic [1:0]      lane;	// Little-endian byte lane
	logic [XLEN-1:0] word_rd;
	logic [7:0]      byte_rd;

	assign word_idx = addr[AW+1:2];
	assign lane     = addr[1:0];
	assign word_rd  = mem[word_idx];
	assign byte_rd  = word_rd[8*lane +: 8];
	assign rdata    = byte_mode ? {{(XLEN-8){byte_rd[7]}}, byte_rd} : word_rd;	// LB sign-extends

	always_ff @(posedge clk)
	begin
		if (rst_n && we)
		begin
			if (byte_mode)
				mem[word_idx][8*lane +: 8] <= wdata[7:0];	// SB touches one lane
			else
				mem[word_idx] <= wdata;
		end
	end

	// Word stores come from the decoder with an aligned effective address
	a_word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
		(we && !byte_mode) |-> (addr[1:0] == 2'b00))
		else $error("data_mem: unaligned word store to %h", addr);

endmodule

//--- rtl/core_top.sv
`timescale 1ns/10ps
module core_top import mips_isa_pkg::*, core_ctrl_pkg::*; #(
	parameter  int IMEM_WORDS = 64,
	parameter  int DMEM_WORDS = 64,
	localparam int IAW        = $clog2(IMEM_WORDS)
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  run,	// Low means program loading
	input  logic                  imem_we,
	input  logic [IAW-1:0]        imem_addr,
	input  logic [XLEN-1:0]       imem_wdata,
	output logic [IAW-1:0]        pc,
	output logic                  wb_en,
	output logic [REG_ADDR_W-1:0] wb_addr,
	output logic [XLEN-1:0]       wb_data,
	output logic                  dmem_we,
	output logic [XLEN-1:0]       dmem_addr,
	output logic [XLEN-1:0]       dmem_wdata
);

	logic [XLEN-1:0]       instr;
	logic [OPCODE_W-1:0]   opcode;
	logic [REG_ADDR_W-1:0] rs, rt, rd;
	logic [4:0]            shamt;
	logic [FUNCT_W-1:0]    funct;
	logic [IMM_W-1:0]      imm;
	logic [JADDR_W-1:0]    jaddr;
	pc_src_e               pc_src;
	reg_dst_e              reg_dst;
	wb_src_e               wb_src;
	alu_class_e            alu_class;
	alu_op_e               alu_op;
	logic                  alu_imm, reg_we, mem_we, branch_eq, imm_signed, mem_byte;
	logic [XLEN-1:0]       rs_data, rt_data, imm_ext, alu_b, alu_result, mem_rdata;
	logic                  alu_zero;
	logic [IAW-1:0]        pc_plus1;

	assign opcode = instr[31:26];	// Instruction fields
	assign rs     = instr[25:21];
	assign rt     = instr[20:16];
	assign rd     = instr[15:11];
	assign shamt  = instr[10:6];
	assign funct  = instr[5:0];
	assign imm    = instr[IMM_W-1:0];
	assign jaddr  = instr[JADDR_W-1:0];

	assign imm_ext = imm_signed ? {{(XLEN-IMM_W){imm[IMM_W-1]}}, imm}
		: {{(XLEN-IMM_W){1'b0}}, imm};
	assign alu_b   = alu_imm ? imm_ext : rt_data;

	always_comb
	begin
		case (reg_dst)
			DST_RD:  wb_addr = rd;
			DST_RA:  wb_addr = RA_REG;
			default: wb_addr = rt;
		endcase
		case (wb_src)
			WB_MEM:  wb_data = mem_rdata;
			WB_LINK: wb_data = XLEN'(pc_plus1);	// Return address in words
			default: wb_data = alu_result;
		endcase
	end

	assign wb_en      = reg_we & run;	// No commits while loading
	assign dmem_we    = mem_we & run;
	assign dmem_addr  = alu_result;
	assign dmem_wdata = rt_data;

	pc_unit #(.IMEM_WORDS(IMEM_WORDS)) u_pc_unit (
		.clk(clk), .rst_n(rst_n), .run(run), .pc_src(pc_src), .branch_eq(branch_eq),
		.zero(alu_zero), .imm_ext(imm_ext), .jaddr(jaddr), .rs_data(rs_data),
		.pc(pc), .pc_plus1(pc_plus1)
	);

	instr_mem #(.IMEM_WORDS(IMEM_WORDS)) u_instr_mem (
		.clk(clk), .rst_n(rst_n), .pc(pc), .instr(instr),
		.load_we(imem_we & ~run), .load_addr(imem_addr), .load_data(imem_wdata)
	);

	control_unit u_control_unit (
		.opcode(opcode), .funct(funct), .rt(rt), .pc_src(pc_src), .reg_dst(reg_dst),
		.wb_src(wb_src), .alu_class(alu_class), .alu_imm(alu_imm), .reg_we(reg_we),
		.mem_we(mem_we), .branch_eq(branch_eq), .imm_signed(imm_signed), .mem_byte(mem_byte)
	);

	alu_control u_alu_control (.alu_class(alu_class), .funct(funct), .alu_op(alu_op));

	reg_file u_reg_file (
		.clk(clk), .rst_n(rst_n), .rs_addr(rs), .rt_addr(rt), .rs_data(rs_data),
		.rt_data(rt_data), .we(wb_en), .wr_addr(wb_addr), .wr_data(wb_data)
	);

	alu u_alu (
		.a(rs_data), .b(alu_b), .shamt(shamt), .alu_op(alu_op),
		.result(alu_result), .zero(alu_zero)
	);

	data_mem #(.DMEM_WORDS(DMEM_WORDS)) u_data_mem (
		.clk(clk), .rst_n(rst_n), .we(dmem_we), .byte_mode(mem_byte),
		.addr(alu_result), .wdata(rt_data), .rdata(mem_rdata)
	);

endmodule

//--- dv/tb_core.sv
`timescale 1ns/10ps
module tb_core import mips_isa_pkg::*; ();

	localparam int IMEM_WORDS  = 64;
	localparam int DMEM_WORDS  = 64;
	localparam int IAW         = $clog2(IMEM_WORDS);
	localparam int STIM_WORDS  = 256;
	localparam int PROG_BASE   = 'h08;	// Program image offset
	localparam int REC_BASE    = 'h40;	// Trace records, kind/addr/data
	localparam int KIND_REG    = 1;
	localparam int KIND_MEM    = 2;
	localparam int RUN_TIMEOUT = 1000;	// Cycles to drain the trace
	localparam int PC_TIMEOUT  = 32;	// Cycles to reach the halt loop

	logic                  clk;
	logic                  rst_n;
	logic                  run;
	logic                  imem_we;
	logic [IAW-1:0]        imem_addr;
	logic [XLEN-1:0]       imem_wdata;
	logic [IAW-1:0]        pc;
	logic                  wb_en;
	logic [REG_ADDR_W-1:0] wb_addr;
	logic [XLEN-1:0]       wb_data;
	logic                  dmem_we;
	logic [XLEN-1:0]       dmem_addr;
	logic [XLEN-1:0]       dmem_wdata;

	logic [XLEN-1:0] stim [STIM_WORDS];	// Whole stimulus image
	int              n_prog;
	int              n_rec;
	int              final_pc;
	int              rec_idx;	// Next expected trace record

	core_top #(.IMEM_WORDS(IMEM_WORDS), .DMEM_WORDS(DMEM_WORDS)) u_core_top (
		.clk(clk), .rst_n(rst_n), .run(run), .imem_we(imem_we), .imem_addr(imem_addr),
		.imem_wdata(imem_wdata), .pc(pc), .wb_en(wb_en), .wb_addr(wb_addr),
		.wb_data(wb_data), .dmem_we(dmem_we), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata)
	);

	initial
	begin
		clk = 1'b0;
		forever #5 clk = ~clk;	// 10 ns period
	end

	task automatic stop_with_fail();
		$display("TEST RESULT: FAIL");
		$fatal(1, "tb_core stopped at the first failure");
	endtask

	task automatic report_mismatch(input string msg);
		$display("ERROR at %0t ns: %s", $time, msg);
		stop_with_fail();
	endtask

	task automatic abort_run(input string msg);
		$display("%s", msg);
		stop_with_fail();
	endtask

	task automatic check_pc(input logic [IAW-1:0] act, input logic [IAW-1:0] exp);
		if (act !== exp)
			report_mismatch($sformatf("pc = %0d, expected %0d", act, exp));
	endtask

	task automatic check_reg_write(input logic [REG_ADDR_W-1:0] addr,
		input logic [XLEN-1:0] data);
		logic [XLEN-1:0] kind;
		logic [XLEN-1:0] exp_addr;
		logic [XLEN-1:0] exp_data;
		if (rec_idx >= n_rec)
			abort_run($sformatf("Unexpected write to r%0d after the last trace record",
				addr));
		kind     = stim[REC_BASE + 3*rec_idx];
		exp_addr = stim[REC_BASE + 3*rec_idx + 1];
		exp_data = stim[REC_BASE + 3*rec_idx + 2];
		if (kind != KIND_REG)
			report_mismatch($sformatf("record %0d expects a memory write, got r%0d = %h",
				rec_idx, addr, data));
		if (addr !== exp_addr[REG_ADDR_W-1:0] || data !== exp_data)
			report_mismatch($sformatf("record %0d wrote r%0d = %h, expected r%0d = %h",
				rec_idx, addr, data, exp_addr, exp_data));
		rec_idx++;
	endtask

	task automatic check_mem_write(input logic [XLEN-1:0] addr, input logic [XLEN-1:0] data);
		logic [XLEN-1:0] kind;
		logic [XLEN-1:0] exp_addr;
		logic [XLEN-1:0] exp_data;
		if (rec_idx >= n_rec)
			abort_run($sformatf("Unexpected memory write to %h after the last trace record",
				addr));
		kind     = stim[REC_BASE + 3*rec_idx];
		exp_addr = stim[REC_BASE + 3*rec_idx + 1];
		exp_data = stim[REC_BASE + 3*rec_idx + 2];
		if (kind != KIND_MEM)
			report_mismatch($sformatf("record %0d expects a register write, got mem[%h] = %h",
				rec_idx, addr, data));
		if (addr !== exp_addr || data !== exp_data)
			report_mismatch($sformatf("record %0d stored mem[%h] = %h, expected mem[%h] = %h",
				rec_idx, addr, data, exp_addr, exp_data));
		rec_idx++;
	endtask

	// Commit strobes settle mid-cycle before the edge that commits them
	always @(negedge clk)
	begin
		if (rst_n)
		begin
			if (wb_en)
				check_reg_write(wb_addr, wb_data);
			if (dmem_we)
				check_mem_write(dmem_addr, dmem_wdata);
		end
	end

	task automatic wait_trace_done();
		int cycles;
		cycles = 0;
		while (rec_idx < n_rec && cycles < RUN_TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
		end
		if (rec_idx < n_rec)
			abort_run($sformatf("Timeout after %0d cycles with %0d of %0d trace records seen",
				cycles, rec_idx, n_rec));
	endtask

	task automatic wait_final_pc();
		int cycles;
		cycles = 0;
		@(negedge clk);	// pc is stable mid-cycle
		while (pc != IAW'(final_pc) && cycles < PC_TIMEOUT)
		begin
			@(negedge clk);
			cycles++;
		end
		check_pc(pc, IAW'(final_pc));	// Halt loop reached
	endtask

	initial
	begin
		rst_n      = 1'b0;
		run        = 1'b0;
		imem_we    = 1'b0;
		imem_addr  = '0;
		imem_wdata = '0;
		rec_idx    = 0;
		$readmemh("dv/core_stimulus.txt", stim);
		if ($isunknown(stim[0]) || $isunknown(stim[1]) || $isunknown(stim[2]))
			abort_run("Stimulus header is missing from dv/core_stimulus.txt");
		n_prog   = int'(stim[0]);
		n_rec    = int'(stim[1]);
		final_pc = int'(stim[2]);
		if (n_prog > IMEM_WORDS || REC_BASE + 3*n_rec > STIM_WORDS)
			abort_run("Stimulus counts do not fit the program or trace area");

		repeat (4) @(posedge clk);	// Reset held 4 cycles
		rst_n <= 1'b1;
		@(negedge clk);
		check_pc(pc, '0);	// Core parked at word 0

		for (int i = 0; i < n_prog; i++)
		begin
			@(posedge clk);
			imem_we    <= 1'b1;
			imem_addr  <= IAW'(i);
			imem_wdata <= stim[PROG_BASE + i];
		end
		@(negedge clk);
		check_pc(pc, '0);	// Loading leaves the PC alone
		@(posedge clk);
		imem_we <= 1'b0;	// Last word is written on this edge
		run     <= 1'b1;

		wait_trace_done();
		wait_final_pc();
		if (rec_idx == n_rec && pc == IAW'(final_pc))
		begin
			$display("TEST RESULT: PASS");
			$finish;
		end
		else
		begin
			abort_run("Run ended with the trace or the final PC incomplete");
		end
	end

endmodule

//--- dv/core_stimulus.txt
// Header at 0x00: program word count, trace record count, final PC (words)
// Program from 0x08; records from 0x40 as kind addr data, kind 1 = register, 2 = memory
@00
00000035 00000024 00000034
@08
20010005 2002FFFD 00221820 00222022 00222824 00223025 00223826 00224027
0041482A 00025100 00025F02 00026043 70226802 304E8F0F 340F8001 3850FFFF
3C118765 26324321 AC120008 A0010009 8C130008 8014000B 80150009 10350001
20160111 14350001 20160022 10220001 20170033 14220001 20180044 04410001
04010001 20190055 04310002 20190066 20190077 0C000028 201A0088 0800002B
201B0099 03E00008 201B00AA 2005002F 00A03009 201C00BB 201C00CC 20000123
0001E820 201E0002 23DEFFFF 17C0FFFE 08000034
@40
// Immediates, then ADD SUB AND OR XOR NOR SLT
00000001 01 00000005  00000001 02 FFFFFFFD
00000001 03 00000002  00000001 04 00000008
00000001 05 00000005  00000001 06 FFFFFFFD
00000001 07 FFFFFFF8  00000001 08 00000002
// SLT, SLL, SRL, SRA, MUL
00000001 09 00000001  00000001 0A FFFFFFD0
00000001 0B 0000000F  00000001 0C FFFFFFFE
// MUL, ANDI ORI XORI zero-extended, LUI, ADDIU
00000001 0D FFFFFFF1  00000001 0E 00008F0D
00000001 0F 00008001  00000001 10 FFFF0002
00000001 11 87650000  00000001 12 87654321
// SW, SB lane 1, LW, LB lane 3 and lane 1
00000002 08 87654321  00000002 09 00000005
00000001 13 87650521  00000001 14 FFFFFF87
// Branch survivors, BGEZAL and JAL links, subroutine, return
00000001 15 00000005  00000001 16 00000022
00000001 17 00000033  00000001 1F 00000023
00000001 1F 00000026  00000001 1B 00000099
// JALR target and link, r0 write, ADD from r0, countdown loop
00000001 1A 00000088  00000001 05 0000002F
00000001 06 0000002D  00000001 00 00000123
00000001 1D 00000005  00000001 1E 00000002
00000001 1E 00000001  00000001 1E 00000000

//--- build.f
common/mips_isa_pkg.sv
common/core_ctrl_pkg.sv
rtl/control/control_unit.sv
rtl/control/alu_control.sv
rtl/execute/alu.sv
rtl/execute/reg_file.sv
rtl/fetch/instr_mem.sv
rtl/fetch/pc_unit.sv
rtl/data_mem.sv
rtl/core_top.sv
dv/tb_core.sv

//--- Makefile
# Verilator flow for the single-cycle MIPS-subset core

VERILATOR  ?= verilator
TOP        ?= tb_core
LINT_TOP   ?= core_top
FILELIST   ?= build.f
OBJ_DIR    ?= obj_dir
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall
PASS_MSG   ?= TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(LINT_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
